/* flist.f */
hdl/sdspi_pkg.sv
hdl/cmd_frame_rx.sv
hdl/card_slot.sv
hdl/resp_serializer.sv
hdl/sdspi_multislot.sv
bench/sdspi_checker.sv
bench/sdspi_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SD SPI responder testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"
PASS_MSG="Simulation finished: PASS"

if ! verilator --binary --assert -sv -Wno-fatal -f flist.f \
    --top-module sdspi_tb -Mdir obj_dir -o sdspi_sim > "$BUILD_LOG" 2>&1; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sdspi_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$SIM_LOG"; then
  echo "Testbench reported failure"
  exit 1
fi

if ! grep -q "$PASS_MSG" "$SIM_LOG"; then
  echo "Testbench ended without a verdict"
  exit 1
fi

exit 0

/* bench/sdspi_tb.sv */
`timescale 1ns/1ps

module sdspi_tb;

  localparam int N_SLOTS          = 4;
  localparam int INIT_POLLS       = 2;
  localparam int N_RANDOM         = 200;
  localparam int N_FRAMES         = N_RANDOM + 50;
  localparam int CYCLES_PER_FRAME = 120;
  localparam int TIMEOUT_NS       = (N_FRAMES * CYCLES_PER_FRAME + 2000) * 40;

  typedef struct packed {
    logic       idle;
    logic       app;
    logic [3:0] polls;
    logic       hcs;
    logic       err;
  } slot_state_t;

  typedef struct packed {
    slot_state_t next;
    logic [39:0] data;
    logic        is_long;
  } expect_t;

  typedef struct packed {
    logic [1:0]         slot;
    logic [39:0]        data;
    logic               is_long;
    logic               tail_high;
    logic [N_SLOTS-1:0] err;
  } result_t;

  logic               sck;
  logic               arst_n;
  logic               mosi;
  logic               miso;
  logic [N_SLOTS-1:0] cs_n;
  logic [N_SLOTS-1:0] cmd_error;

  slot_state_t model [N_SLOTS];
  result_t     exp_q[$];
  result_t     got_q[$];
  event        result_ready;
  logic [15:0] lfsr;
  int          errors;
  int          checks;
  int          frames_sent;

  sdspi_multislot #(
    .N_SLOTS    (N_SLOTS),
    .INIT_POLLS (INIT_POLLS)
  ) dut (
    .sck       (sck),
    .arst_n    (arst_n),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .cmd_error (cmd_error)
  );

  initial begin
    sck = 1'b0;
    forever #20 sck = ~sck;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired at %0t after %0d frames, DUT stopped answering", $time,
             frames_sent);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic check(input string name, input logic [39:0] got, input logic [39:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Galois LFSR with taps 16, 14, 13 and 11
  function automatic logic next_random_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_random_bit()};
    end
    return v;
  endfunction

  // Long division by x^7 + x^3 + 1
  function automatic logic [6:0] calc_crc7(input logic [39:0] msg);
    logic [46:0] rem;
    rem = {msg, 7'h00};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  function automatic logic [47:0] build_frame(input logic [5:0] index, input logic [31:0] arg);
    logic [39:0] head;
    head = {2'b01, index, arg};
    return {head, calc_crc7(head), 1'b1};
  endfunction

  function automatic logic [5:0] pick_index(input int k);
    case (k)
      0:       return sdspi_pkg::CMD0;
      1:       return sdspi_pkg::CMD8;
      2:       return sdspi_pkg::CMD17;
      3:       return sdspi_pkg::CMD24;
      4:       return sdspi_pkg::CMD41;
      5:       return sdspi_pkg::CMD55;
      default: return sdspi_pkg::CMD58;
    endcase
  endfunction

  // Card behaviour as seen by the host
  function automatic expect_t predict(input slot_state_t st, input logic [47:0] bits);
    expect_t     e;
    logic        ok;
    logic        illegal;
    logic [31:0] arg;
    logic [31:0] tail;
    logic [7:0]  r1;
    e.next    = st;
    e.is_long = 1'b0;
    tail      = '0;
    illegal   = 1'b0;
    arg       = bits[39:8];
    ok        = (calc_crc7(bits[47:8]) == bits[7:1]) && bits[0];
    if (ok) begin
      e.next.app = 1'b0;
      case (bits[45:40])
        sdspi_pkg::CMD0: begin
          e.next.idle  = 1'b1;
          e.next.polls = '0;
          e.next.err   = 1'b0;
        end
        sdspi_pkg::CMD8: begin
          e.is_long = 1'b1;
          tail      = {20'h00000, arg[11:8], arg[7:0]};
        end
        sdspi_pkg::CMD55: e.next.app = 1'b1;
        sdspi_pkg::CMD41: begin
          if (st.app) begin
            e.next.hcs = arg[30];
            if (st.polls < INIT_POLLS) begin
              e.next.polls = st.polls + 4'd1;
            end
            if (e.next.polls == INIT_POLLS) begin
              e.next.idle = 1'b0;
            end
          end else begin
            illegal = 1'b1;
          end
        end
        sdspi_pkg::CMD58: begin
          e.is_long = 1'b1;
          tail      = {~st.idle, st.hcs, 30'h0} | 32'h0030_0000;
        end
        default: illegal = 1'b1;
      endcase
      if (illegal) begin
        e.next.err = 1'b1;
      end
    end
    r1 = 8'h00;
    r1[sdspi_pkg::R1_IDLE]    = e.next.idle;
    r1[sdspi_pkg::R1_ILLEGAL] = illegal;
    r1[sdspi_pkg::R1_CRC_ERR] = !ok;
    e.data = {r1, tail};
    return e;
  endfunction

  task automatic send_frame(input int slot, input logic [47:0] bits);
    expect_t e;
    result_t exp_r;
    result_t got_r;
    int      nbits;
    e           = predict(model[slot], bits);
    model[slot] = e.next;
    exp_r           = '0;
    exp_r.slot      = slot[1:0];
    exp_r.data      = e.data;
    exp_r.is_long   = e.is_long;
    exp_r.tail_high = 1'b1;
    for (int s = 0; s < N_SLOTS; s++) begin
      exp_r.err[s] = model[s].err;
    end
    @(posedge sck);
    #2 cs_n[slot] = 1'b0;
    for (int i = 47; i >= 0; i--) begin
      @(posedge sck);
      #2 mosi = bits[i];
    end
    @(posedge sck);
    #2 mosi = 1'b1;
    // Response starts after the serializer loads, two edges on
    repeat (2) @(posedge sck);
    nbits         = e.is_long ? 40 : 8;
    got_r         = '0;
    got_r.slot    = slot[1:0];
    got_r.is_long = e.is_long;
    for (int i = 0; i < nbits; i++) begin
      @(negedge sck);
      got_r.data[39-i] = miso;
    end
    @(negedge sck);
    got_r.tail_high = miso;
    got_r.err       = cmd_error;
    exp_q.push_back(exp_r);
    got_q.push_back(got_r);
    -> result_ready;
    @(posedge sck);
    #2 cs_n[slot] = 1'b1;
    frames_sent++;
  endtask

  task automatic send_cmd(input int slot, input logic [5:0] index, input logic [31:0] arg);
    send_frame(slot, build_frame(index, arg));
  endtask

  task automatic abort_frame(input int slot, input logic [47:0] bits, input int keep);
    @(posedge sck);
    #2 cs_n[slot] = 1'b0;
    for (int i = 47; i > 47 - keep; i--) begin
      @(posedge sck);
      #2 mosi = bits[i];
    end
    @(posedge sck);
    #2 cs_n[slot] = 1'b1;
    mosi = 1'b1;
    for (int i = 0; i < 48; i++) begin
      @(negedge sck);
      check("miso after aborted frame", 40'(miso), 40'h1);
    end
    frames_sent++;
  endtask

  task automatic init_slot(input int slot, input logic hcs);
    send_cmd(slot, sdspi_pkg::CMD8, 32'h0000_01AA);
    for (int p = 0; p < INIT_POLLS; p++) begin
      send_cmd(slot, sdspi_pkg::CMD55, 32'h0);
      send_cmd(slot, sdspi_pkg::CMD41, {1'b0, hcs, 30'h0});
    end
    send_cmd(slot, sdspi_pkg::CMD58, 32'h0);
  endtask

  initial begin : compare
    result_t e;
    result_t g;
    forever begin
      @(result_ready);
      while (got_q.size() > 0) begin
        g = got_q.pop_front();
        e = exp_q.pop_front();
        for (int b = 0; b < (e.is_long ? 5 : 1); b++) begin
          check($sformatf("miso byte %0d of slot %0d", b, e.slot),
                40'(g.data[39-8*b -: 8]), 40'(e.data[39-8*b -: 8]));
        end
        check("miso after response", 40'(g.tail_high), 40'(e.tail_high));
        check("cmd_error", 40'(g.err), 40'(e.err));
      end
    end
  end

  initial begin : main
    logic [47:0] bits;
    logic [5:0]  index;
    logic [31:0] arg;
    int          slot;
    int          k;
    arst_n      = 1'b0;
    cs_n        = '1;
    mosi        = 1'b1;
    lfsr        = 16'd62;
    errors      = 0;
    checks      = 0;
    frames_sent = 0;
    for (int s = 0; s < N_SLOTS; s++) begin
      model[s]      = '0;
      model[s].idle = 1'b1;
    end
    repeat (8) @(posedge sck);
    #2 arst_n = 1'b1;

    for (int s = 0; s < N_SLOTS; s++) begin
      send_cmd(s, sdspi_pkg::CMD0, 32'h0);
    end
    // Slot 0 must still be idle while only slot 2 is ready
    init_slot(2, 1'b1);
    send_cmd(0, sdspi_pkg::CMD58, 32'h0);
    init_slot(0, 1'b0);
    init_slot(1, 1'b1);
    init_slot(3, 1'b0);

    bits    = build_frame(sdspi_pkg::CMD0, 32'h0);
    bits[1] = ~bits[1];
    send_frame(1, bits);
    bits    = build_frame(sdspi_pkg::CMD58, 32'h0);
    bits[0] = 1'b0;
    send_frame(1, bits);
    send_cmd(1, sdspi_pkg::CMD58, 32'h0);

    send_cmd(3, sdspi_pkg::CMD17, 32'h0);
    send_cmd(3, sdspi_pkg::CMD24, 32'h0);
    send_cmd(3, sdspi_pkg::CMD41, 32'h4000_0000);
    send_cmd(3, sdspi_pkg::CMD58, 32'h0);
    send_cmd(3, sdspi_pkg::CMD0, 32'h0);

    abort_frame(0, build_frame(sdspi_pkg::CMD0, 32'h0), 20);
    send_cmd(0, sdspi_pkg::CMD58, 32'h0);

    for (int n = 0; n < N_RANDOM; n++) begin
      slot  = int'(random_bits(2));
      k     = int'(random_bits(3)) % 7;
      index = pick_index(k);
      arg   = random_bits(32);
      bits  = build_frame(index, arg);
      // Roughly one frame in eight gets a CRC or end bit flipped
      if (random_bits(3) == 32'h0) begin
        k       = int'(random_bits(3));
        bits[k] = ~bits[k];
      end
      send_frame(slot, bits);
    end

    repeat (2) @(posedge sck);
    $display("Summary: %0d errors in %0d checks over %0d frames", errors, checks, frames_sent);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* bench/sdspi_checker.sv */
`timescale 1ns/1ps

module sdspi_checker #(
  parameter int N_SLOTS = 4
) (
  input logic               sck,
  input logic               arst_n,
  input logic               miso,
  input logic [N_SLOTS-1:0] frame_hit,
  input logic [N_SLOTS-1:0] resp_valid,
  input logic [N_SLOTS-1:0] cmd_error
);

  // A frame belongs to one slot at most
  a_hit_onehot: assert property (
    @(posedge sck) disable iff (!arst_n) $onehot0(frame_hit)
  ) else $error("frame_hit has more than one bit set: %b", frame_hit);

  a_valid_after_hit: assert property (
    @(posedge sck) disable iff (!arst_n) resp_valid == $past(frame_hit)
  ) else $error("resp_valid %b does not follow frame_hit by one cycle", resp_valid);

  // Outputs at rest right after reset
  a_reset_release: assert property (
    @(posedge sck) $rose(arst_n) |-> (miso && (cmd_error == '0))
  ) else $error("miso or cmd_error not at rest after reset release");

endmodule

bind sdspi_multislot sdspi_checker #(
  .N_SLOTS (N_SLOTS)
) u_checker (
  .sck        (sck),
  .arst_n     (arst_n),
  .miso       (miso),
  .frame_hit  (frame_hit),
  .resp_valid (resp_valid),
  .cmd_error  (cmd_error)
);

/* hdl/sdspi_multislot.sv */
`timescale 1ns/1ps

module sdspi_multislot #(
  parameter int N_SLOTS    = 4,
  parameter int INIT_POLLS = 2
) (
  input  logic               sck,
  input  logic               arst_n,
  input  logic [N_SLOTS-1:0] cs_n,
  input  logic               mosi,
  output logic               miso,
  output logic [N_SLOTS-1:0] cmd_error
);

  sdspi_pkg::cmd_frame_t           frame;
  logic [N_SLOTS-1:0]              frame_hit;
  logic [N_SLOTS-1:0]              resp_valid;
  sdspi_pkg::resp_t [N_SLOTS-1:0]  resp;

  cmd_frame_rx #(
    .N_SLOTS (N_SLOTS)
  ) u_rx (
    .sck       (sck),
    .arst_n    (arst_n),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .frame     (frame),
    .frame_hit (frame_hit)
  );

  for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
    card_slot #(
      .INIT_POLLS (INIT_POLLS)
    ) u_slot (
      .sck        (sck),
      .arst_n     (arst_n),
      .frame      (frame),
      .hit        (frame_hit[i]),
      .resp_valid (resp_valid[i]),
      .resp       (resp[i]),
      .cmd_error  (cmd_error[i])
    );
  end

  resp_serializer #(
    .N_SLOTS (N_SLOTS)
  ) u_ser (
    .sck        (sck),
    .arst_n     (arst_n),
    .resp_valid (resp_valid),
    .resp       (resp),
    .miso       (miso)
  );

endmodule

/* hdl/resp_serializer.sv */
`timescale 1ns/1ps

module resp_serializer #(
  parameter int N_SLOTS = 4
) (
  input  logic                            sck,
  input  logic                            arst_n,
  input  logic [N_SLOTS-1:0]              resp_valid,
  input  sdspi_pkg::resp_t [N_SLOTS-1:0]  resp,
  output logic                            miso
);

  sdspi_pkg::resp_t sel;
  logic             load;
  logic [39:0]      shreg;
  logic [5:0]       bit_cnt;

  assign load = |resp_valid;

  // At most one slot answers per cycle
  always_comb begin
    sel = resp[0];
    for (int i = 1; i < N_SLOTS; i++) begin
      if (resp_valid[i]) begin
        sel = resp[i];
      end
    end
  end

  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt <= '0;
    end else if (load) begin
      bit_cnt <= sel.is_long ? 6'd40 : 6'd8;
    end else if (bit_cnt != '0) begin
      bit_cnt <= bit_cnt - 6'd1;
    end
  end

  always_ff @(posedge sck) begin
    if (load) begin
      shreg <= sel.data;
    end else begin
      shreg <= {shreg[38:0], 1'b1};
    end
  end

  // Line rests high with nothing left to send
  assign miso = (bit_cnt != '0) ? shreg[39] : 1'b1;

endmodule

/* hdl/card_slot.sv */
`timescale 1ns/1ps

module card_slot #(
  parameter int INIT_POLLS = 2
) (
  input  logic                  sck,
  input  logic                  arst_n,
  input  sdspi_pkg::cmd_frame_t frame,
  input  logic                  hit,
  output logic                  resp_valid,
  output sdspi_pkg::resp_t      resp,
  output logic                  cmd_error
);

  localparam int PW = (INIT_POLLS > 0) ? $clog2(INIT_POLLS + 1) : 1;

  // Voltage window reported in the OCR
  localparam logic [31:0] OCR_VDD = 32'h0030_0000;

  logic          idle;
  logic          app_cmd;
  logic [PW-1:0] poll_cnt;
  logic          hcs;

  logic          idle_d;
  logic          app_cmd_d;
  logic [PW-1:0] poll_cnt_d;
  logic          hcs_d;
  logic          err_d;
  logic          illegal;
  logic          long_d;
  logic [7:0]    r1;
  logic [31:0]   tail;

  always_comb begin
    idle_d     = idle;
    app_cmd_d  = app_cmd;
    poll_cnt_d = poll_cnt;
    hcs_d      = hcs;
    err_d      = cmd_error;
    illegal    = 1'b0;
    long_d     = 1'b0;
    tail       = '0;
    r1         = '0;

    // A bad frame is only reported and changes no state
    if (frame.frame_ok) begin
      app_cmd_d = 1'b0;
      case (frame.index)
        sdspi_pkg::CMD0: begin
          idle_d     = 1'b1;
          poll_cnt_d = '0;
          err_d      = 1'b0;
        end
        sdspi_pkg::CMD8: begin
          long_d = 1'b1;
          tail   = {16'h0000, 4'h0, frame.arg.cmd8.vhs, frame.arg.cmd8.pattern};
        end
        sdspi_pkg::CMD55: begin
          app_cmd_d = 1'b1;
        end
        sdspi_pkg::CMD41: begin
          if (app_cmd) begin
            hcs_d = frame.arg.acmd41.hcs;
            if (poll_cnt != PW'(INIT_POLLS)) begin
              poll_cnt_d = poll_cnt + 1'b1;
            end
            if (poll_cnt_d == PW'(INIT_POLLS)) begin
              idle_d = 1'b0;
            end
          end else begin
            illegal = 1'b1;
          end
        end
        sdspi_pkg::CMD58: begin
          long_d = 1'b1;
          tail   = OCR_VDD | {~idle, hcs, 30'h0};
        end
        default: illegal = 1'b1;
      endcase
      if (illegal) begin
        err_d = 1'b1;
      end
    end

    r1[sdspi_pkg::R1_IDLE]    = idle_d;
    r1[sdspi_pkg::R1_ILLEGAL] = illegal;
    r1[sdspi_pkg::R1_CRC_ERR] = !frame.frame_ok;
  end

  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      idle       <= 1'b1;
      app_cmd    <= 1'b0;
      poll_cnt   <= '0;
      hcs        <= 1'b0;
      cmd_error  <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= hit;
      if (hit) begin
        idle      <= idle_d;
        app_cmd   <= app_cmd_d;
        poll_cnt  <= poll_cnt_d;
        hcs       <= hcs_d;
        cmd_error <= err_d;
      end
    end
  end

  always_ff @(posedge sck) begin
    if (hit) begin
      resp.data    <= {r1, tail};
      resp.is_long <= long_d;
    end
  end

endmodule

/* hdl/cmd_frame_rx.sv */
`timescale 1ns/1ps

module cmd_frame_rx #(
  parameter int N_SLOTS = 4
) (
  input  logic                   sck,
  input  logic                   arst_n,
  input  logic [N_SLOTS-1:0]     cs_n,
  input  logic                   mosi,
  output sdspi_pkg::cmd_frame_t  frame,
  output logic [N_SLOTS-1:0]     frame_hit
);

  typedef enum logic [1:0] {
    HUNT,
    START,
    RECV
  } rx_state_e;

  rx_state_e          state;
  logic [5:0]         bit_cnt;
  logic [47:0]        shreg;
  logic [N_SLOTS-1:0] slot;
  logic [47:0]        full;
  logic               one_sel;
  logic               slot_lost;
  logic               done;

  // Frame as it stands including the bit sampled on this edge
  assign full      = {shreg[46:0], mosi};
  assign one_sel   = $onehot(~cs_n);
  assign slot_lost = |(cs_n & slot);
  assign done      = (state == RECV) && (bit_cnt == 6'd1) && !slot_lost;

  always_ff @(posedge sck) begin
    shreg <= full;
  end

  always_ff @(posedge sck or negedge arst_n) begin
    if (!arst_n) begin
      state     <= HUNT;
      bit_cnt   <= '0;
      slot      <= '0;
      frame_hit <= '0;
    end else begin
      frame_hit <= '0;
      case (state)
        HUNT: begin
          if (!mosi && one_sel) begin
            state <= START;
            slot  <= ~cs_n;
          end
        end
        START: begin
          if (slot_lost) begin
            state <= HUNT;
          end else if (mosi) begin
            // Transmission bit seen and 46 bits still to come
            state   <= RECV;
            bit_cnt <= 6'd46;
          end else if (!one_sel) begin
            state <= HUNT;
          end
        end
        RECV: begin
          if (slot_lost) begin
            state <= HUNT;
          end else if (done) begin
            state     <= HUNT;
            frame_hit <= slot;
          end else begin
            bit_cnt <= bit_cnt - 6'd1;
          end
        end
        default: state <= HUNT;
      endcase
    end
  end

  always_ff @(posedge sck) begin
    if (done) begin
      frame.index    <= full[45:40];
      frame.arg.raw  <= full[39:8];
      frame.frame_ok <= (sdspi_pkg::crc7(full[47:8]) == full[7:1]) && full[0];
    end
  end

endmodule

/* hdl/sdspi_pkg.sv */
package sdspi_pkg;

  // Command indices known to the responder
  typedef enum logic [5:0] {
    CMD0  = 6'd0,
    CMD8  = 6'd8,
    CMD17 = 6'd17,
    CMD24 = 6'd24,
    CMD41 = 6'd41,
    CMD55 = 6'd55,
    CMD58 = 6'd58
  } cmd_index_e;

  // R1 flag positions
  localparam int R1_IDLE    = 0;
  localparam int R1_ILLEGAL = 2;
  localparam int R1_CRC_ERR = 3;

  typedef struct packed {
    logic [19:0] reserved;
    logic [3:0]  vhs;
    logic [7:0]  pattern;
  } cmd8_arg_t;

  typedef struct packed {
    logic        reserved_hi;
    logic        hcs;
    logic [29:0] reserved_lo;
  } acmd41_arg_t;

  // Same argument word, decoded per command
  typedef union packed {
    logic [31:0] raw;
    cmd8_arg_t   cmd8;
    acmd41_arg_t acmd41;
  } cmd_arg_u;

  typedef struct packed {
    logic [5:0] index;
    cmd_arg_u   arg;
    logic       frame_ok;
  } cmd_frame_t;

  // First response byte sits in data[39:32]
  typedef struct packed {
    logic [39:0] data;
    logic        is_long;
  } resp_t;

  // CRC7 with x^7 + x^3 + 1 over the leading 40 frame bits
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb       = crc[6] ^ bits[i];
      crc[6:4] = crc[5:3];
      crc[3]   = crc[2] ^ fb;
      crc[2:1] = crc[1:0];
      crc[0]   = fb;
    end
    return crc;
  endfunction

endpackage
